//--- src/pcxt_pkg.sv
/*
	Shared rates, reset counts, register layouts and types for the PC/XT glue.
	Modules import it inside their bodies and use scoped names in their headers.
*/
package pcxt_pkg;

	////////////////////
	// Clock rates in Hz

	// Base clock, also the accumulator modulus
	localparam int unsigned SYS_CLK_HZ       = 50_000_000;
	localparam int unsigned AUDIO_RATE_HZ    = 44_100;
	// Timer input, half the slow CPU rate
	localparam int unsigned PERIPH_RATE_HZ   = 2_386_364;
	localparam int unsigned CPU_RATE_SLOW_HZ = 4_772_727;
	localparam int unsigned CPU_RATE_MID_HZ  = 7_159_091;
	localparam int unsigned CPU_RATE_FAST_HZ = 14_318_182;

	// Wide enough for sum of two sub-modulus terms
	localparam int RATE_ACC_W = 32;

	////////////////////
	// Reset sequencing

	// Hold after all reset sources clear
	localparam int unsigned RESET_HOLD_CYCLES = 65_535;
	// CPU release lag behind system release
	localparam int unsigned CPU_RESET_DELAY   = 42;

	////////////////////
	// Types

	// Code 3 is treated as the slow rate
	typedef enum logic [1:0] {
		SPEED_4M77 = 2'd0,
		SPEED_7M16 = 2'd1,
		SPEED_14M3 = 2'd2
	} cpu_speed_t;

	// Configuration word, unused bits stored as written
	typedef struct packed {
		logic [12:0] rsvd_hi;
		cpu_speed_t  cpu_speed;
		logic [12:0] rsvd_mid;
		logic        model_tandy;
		logic [1:0]  rsvd_lo;
		logic        soft_reset;
	} status_word_t;

	// Read-only state word
	typedef struct packed {
		logic [27:0] zero;
		logic        turbo;
		logic        tandy_mode;
		logic        reset_cpu;
		logic        reset_sys;
	} state_word_t;

	typedef logic [1:0]  wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// Word addresses
	localparam wb_addr_t ADDR_STATUS = 2'd0;
	localparam wb_addr_t ADDR_STATE  = 2'd1;

	// Keyboard line pair
	typedef struct packed {
		logic clk;
		logic data;
	} ps2_lines_t;

endpackage

//--- src/input_sync.sv
/*
	Two-stage synchronizer for an asynchronous input of any packed type.
*/
`timescale 1ns/100ps

module input_sync #(
	parameter type payload_t = logic
) (
	input  logic     CLK_50M,
	input  logic     reset_wire,
	input  logic     clear,
	input  payload_t d,
	output payload_t q
);
	payload_t meta;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			meta <= '0;
			q    <= '0;
		end else if (clear) begin
			// Both stages empty during system reset
			meta <= '0;
			q    <= '0;
		end else begin
			meta <= d;
			q    <= meta;
		end
	end

endmodule

//--- src/rate_strobe.sv
/*
	Fractional accumulator that gives a one-cycle enable at RATE_HZ on average.
*/
`timescale 1ns/100ps

module rate_strobe #(
	parameter int unsigned RATE_HZ = pcxt_pkg::AUDIO_RATE_HZ
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic run,
	output logic strobe
);
	import pcxt_pkg::*;

	localparam logic [RATE_ACC_W-1:0] INCR    = RATE_ACC_W'(RATE_HZ);
	localparam logic [RATE_ACC_W-1:0] MODULUS = RATE_ACC_W'(SYS_CLK_HZ);

	// Rate must stay below the base clock
	if (RATE_HZ >= SYS_CLK_HZ) begin : g_bad_rate
		$error("rate_strobe RATE_HZ must be below SYS_CLK_HZ");
	end

	logic [RATE_ACC_W-1:0] acc;
	logic [RATE_ACC_W-1:0] acc_next;

	assign acc_next = acc + INCR;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc    <= '0;
			strobe <= 1'b0;
		end else if (!run) begin
			// Restart from zero when stopped
			acc    <= '0;
			strobe <= 1'b0;
		end else if (acc_next >= MODULUS) begin
			acc    <= acc_next - MODULUS;
			strobe <= 1'b1;
		end else begin
			acc    <= acc_next;
			strobe <= 1'b0;
		end
	end

endmodule

//--- src/cfg_regs.sv
/*
	Wishbone classic slave for the core configuration word and the status readback.
	One ack per pending cycle, never stalls.
*/
`timescale 1ns/100ps

module cfg_regs (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	// Wishbone classic slave
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  pcxt_pkg::wb_addr_t   wb_adr,
	input  pcxt_pkg::wb_data_t   wb_dat_w,
	output pcxt_pkg::wb_data_t   wb_dat_r,
	output logic                 wb_ack,
	// Live state for readback
	input  logic                 reset_sys,
	input  logic                 reset_cpu,
	input  logic                 tandy_mode,
	input  logic                 turbo,
	// Decoded configuration fields
	output logic                 soft_reset,
	output logic                 model_tandy,
	output pcxt_pkg::cpu_speed_t cpu_speed
);
	import pcxt_pkg::*;

	status_word_t cfg_q;
	state_word_t  state_w;
	logic         pending;

	// Cycle seen but not yet acked
	assign pending = wb_cyc & wb_stb & ~wb_ack;

	////////////////////
	// Ack and write path

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			wb_ack <= 1'b0;
			cfg_q  <= '0;
		end else begin
			// Ack lasts one cycle, strobe must drop before next
			wb_ack <= pending;
			// Write lands on the ack edge
			if (pending && wb_we && (wb_adr == ADDR_STATUS)) begin
				cfg_q <= status_word_t'(wb_dat_w);
			end
		end
	end

	////////////////////
	// Read path

	// State bits straight from the live signals
	always_comb begin
		state_w            = '0;
		state_w.reset_sys  = reset_sys;
		state_w.reset_cpu  = reset_cpu;
		state_w.tandy_mode = tandy_mode;
		state_w.turbo      = turbo;
	end

	// Address held by host until ack, so data valid with ack
	always_comb begin
		case (wb_adr)
			ADDR_STATUS: wb_dat_r = wb_data_t'(cfg_q);
			ADDR_STATE:  wb_dat_r = wb_data_t'(state_w);
			// Spare addresses
			default:     wb_dat_r = '0;
		endcase
	end

	// Field decode
	assign soft_reset  = cfg_q.soft_reset;
	assign model_tandy = cfg_q.model_tandy;
	assign cpu_speed   = cfg_q.cpu_speed;

endmodule

//--- src/reset_sequencer.sv
/*
	System reset stretch, delayed CPU reset release and machine model capture.
	The model may only change while the system is held in reset.
*/
`timescale 1ns/100ps

module reset_sequencer (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic soft_reset,
	input  logic model_tandy,
	output logic reset_sys,
	output logic reset_cpu,
	output logic tandy_mode
);
	import pcxt_pkg::*;

	localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);
	localparam int CPU_W  = $clog2(CPU_RESET_DELAY + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic [CPU_W-1:0]  cpu_cnt;

	////////////////////
	// System reset stretch

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			reset_sys <= 1'b1;
			hold_cnt  <= '0;
		end else if (soft_reset) begin
			// Soft reset restarts the stretch
			reset_sys <= 1'b1;
			hold_cnt  <= '0;
		end else if (reset_sys) begin
			if (hold_cnt == HOLD_W'(RESET_HOLD_CYCLES - 1)) begin
				reset_sys <= 1'b0;
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// CPU reset delay

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			reset_cpu <= 1'b1;
			cpu_cnt   <= '0;
		end else if (soft_reset || reset_sys) begin
			// Same edge as system reset on soft reset
			reset_cpu <= 1'b1;
			cpu_cnt   <= '0;
		end else if (reset_cpu) begin
			if (cpu_cnt == CPU_W'(CPU_RESET_DELAY - 1)) begin
				reset_cpu <= 1'b0;
			end else begin
				cpu_cnt <= cpu_cnt + 1'b1;
			end
		end
	end

	// Model tracks config only under system reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			tandy_mode <= 1'b0;
		end else if (reset_sys) begin
			tandy_mode <= model_tandy;
		end
	end

endmodule

//--- src/clock_enables.sv
/*
	CPU, peripheral, audio and FM clock enables in the single base clock domain.
	CPU speed and turbo change only at bus-cycle boundaries.
*/
`timescale 1ns/100ps

module clock_enables (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	input  logic                 reset_sys,
	input  logic                 biu_done,
	input  pcxt_pkg::cpu_speed_t cpu_speed,
	input  logic                 fm_clk_sync,
	output logic                 cpu_ce,
	output logic                 periph_ce,
	output logic                 audio_ce,
	output logic                 fm_ce,
	output logic                 turbo
);
	import pcxt_pkg::*;

	localparam logic [RATE_ACC_W-1:0] MODULUS = RATE_ACC_W'(SYS_CLK_HZ);

	cpu_speed_t            applied_speed;
	logic [RATE_ACC_W-1:0] cpu_incr;
	logic [RATE_ACC_W-1:0] cpu_acc;
	logic [RATE_ACC_W-1:0] cpu_acc_next;
	logic                  fm_prev;
	logic                  run;

	// Enables only outside system reset
	assign run = ~reset_sys;

	////////////////////
	// Speed latch

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			applied_speed <= SPEED_4M77;
			turbo         <= 1'b0;
		end else if (biu_done) begin
			// Code 3 folds to the slow rate
			if (cpu_speed == SPEED_7M16 || cpu_speed == SPEED_14M3) begin
				applied_speed <= cpu_speed;
				turbo         <= 1'b1;
			end else begin
				applied_speed <= SPEED_4M77;
				turbo         <= 1'b0;
			end
		end
	end

	always_comb begin
		case (applied_speed)
			SPEED_7M16: cpu_incr = RATE_ACC_W'(CPU_RATE_MID_HZ);
			SPEED_14M3: cpu_incr = RATE_ACC_W'(CPU_RATE_FAST_HZ);
			default:    cpu_incr = RATE_ACC_W'(CPU_RATE_SLOW_HZ);
		endcase
	end

	////////////////////
	// CPU enable accumulator

	assign cpu_acc_next = cpu_acc + cpu_incr;

	// Residue carries across a speed change
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_acc <= '0;
			cpu_ce  <= 1'b0;
		end else if (!run) begin
			cpu_acc <= '0;
			cpu_ce  <= 1'b0;
		end else if (cpu_acc_next >= MODULUS) begin
			cpu_acc <= cpu_acc_next - MODULUS;
			cpu_ce  <= 1'b1;
		end else begin
			cpu_acc <= cpu_acc_next;
			cpu_ce  <= 1'b0;
		end
	end

	// FM clock rising edge, one cycle after the sync stage
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			fm_prev <= 1'b0;
			fm_ce   <= 1'b0;
		end else begin
			fm_prev <= fm_clk_sync;
			fm_ce   <= run & fm_clk_sync & ~fm_prev;
		end
	end

	// Fixed-rate enables
	rate_strobe #(
		.RATE_HZ (AUDIO_RATE_HZ)
	) u_audio_strobe (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.run        (run),
		.strobe     (audio_ce)
	);

	rate_strobe #(
		.RATE_HZ (PERIPH_RATE_HZ)
	) u_periph_strobe (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.run        (run),
		.strobe     (periph_ce)
	);

endmodule

//--- src/pcxt_glue_top.sv
/*
	Board glue top for the PC/XT core: config slave, reset sequencing,
	clock enables and input synchronizers, all on CLK_50M.
*/
`timescale 1ns/100ps

module pcxt_glue_top (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	// Wishbone classic slave
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  pcxt_pkg::wb_addr_t   wb_adr,
	input  pcxt_pkg::wb_data_t   wb_dat_w,
	output pcxt_pkg::wb_data_t   wb_dat_r,
	output logic                 wb_ack,
	// CPU bus cycle finished
	input  logic                 biu_done,
	// Async inputs
	input  pcxt_pkg::ps2_lines_t ps2_in,
	input  logic                 fm_clk,
	// Resets and model
	output logic                 reset_sys,
	output logic                 reset_cpu,
	output logic                 tandy_mode,
	output logic                 turbo,
	// Enables
	output logic                 cpu_ce,
	output logic                 periph_ce,
	output logic                 audio_ce,
	output logic                 fm_ce,
	output pcxt_pkg::ps2_lines_t ps2_sync
);
	import pcxt_pkg::*;

	logic       soft_reset;
	logic       model_tandy;
	cpu_speed_t cpu_speed;
	logic       fm_clk_sync;

	////////////////////
	// Config and status

	cfg_regs u_cfg_regs (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.reset_sys   (reset_sys),
		.reset_cpu   (reset_cpu),
		.tandy_mode  (tandy_mode),
		.turbo       (turbo),
		.soft_reset  (soft_reset),
		.model_tandy (model_tandy),
		.cpu_speed   (cpu_speed)
	);

	reset_sequencer u_reset_sequencer (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.soft_reset  (soft_reset),
		.model_tandy (model_tandy),
		.reset_sys   (reset_sys),
		.reset_cpu   (reset_cpu),
		.tandy_mode  (tandy_mode)
	);

	////////////////////
	// Synchronizers

	// Keyboard clock and data
	input_sync #(
		.payload_t (ps2_lines_t)
	) u_ps2_sync (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.clear      (reset_sys),
		.d          (ps2_in),
		.q          (ps2_sync)
	);

	// FM synth clock, edge detected downstream
	input_sync #(
		.payload_t (logic)
	) u_fm_sync (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.clear      (reset_sys),
		.d          (fm_clk),
		.q          (fm_clk_sync)
	);

	clock_enables u_clock_enables (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.reset_sys   (reset_sys),
		.biu_done    (biu_done),
		.cpu_speed   (cpu_speed),
		.fm_clk_sync (fm_clk_sync),
		.cpu_ce      (cpu_ce),
		.periph_ce   (periph_ce),
		.audio_ce    (audio_ce),
		.fm_ce       (fm_ce),
		.turbo       (turbo)
	);

endmodule

//--- bench/pcxt_glue_props.sv
/*
	Concurrent checks on the glue top, bound into every pcxt_glue_top instance.
*/
`timescale 1ns/100ps

module pcxt_glue_props (
	input logic CLK_50M,
	input logic reset_wire,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic reset_sys,
	input logic reset_cpu,
	input logic audio_ce
);
	// Failure count, read by the testbench
	int unsigned assert_fails = 0;

	// Ack only after a pending, unacked cycle
	ack_after_pending: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		wb_ack |-> $past(wb_cyc & wb_stb & ~wb_ack))
		else begin
			$error("wb_ack without a pending cycle");
			assert_fails++;
		end

	// Single-cycle ack
	ack_one_cycle: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack held for two cycles");
			assert_fails++;
		end

	// CPU stays in reset under system reset
	cpu_under_sys: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		reset_sys |-> reset_cpu)
		else begin
			$error("reset_cpu low while reset_sys high");
			assert_fails++;
		end

	audio_spread: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		audio_ce |=> !audio_ce)
		else begin
			$error("audio_ce high on two cycles in a row");
			assert_fails++;
		end

endmodule

bind pcxt_glue_top pcxt_glue_props props0 (
	.CLK_50M    (CLK_50M),
	.reset_wire (reset_wire),
	.wb_cyc     (wb_cyc),
	.wb_stb     (wb_stb),
	.wb_ack     (wb_ack),
	.reset_sys  (reset_sys),
	.reset_cpu  (reset_cpu),
	.audio_ce   (audio_ce)
);

//--- bench/pcxt_glue_tb.sv
/*
	Directed testbench for the PC/XT board glue top.
	Inputs change on the falling edge and outputs are sampled there too.
*/
`timescale 1ns/100ps

module pcxt_glue_tb;
	import pcxt_pkg::*;

	localparam int CLK_HALF       = 10;
	// Strobe count windows in cycles
	localparam int STROBE_WINDOW  = 20_000;
	localparam int CPU_WINDOW     = 5_000;
	// Four reset holds plus all count windows, with slack
	localparam int WATCHDOG_CYCLES = 4 * (RESET_HOLD_CYCLES + CPU_RESET_DELAY)
		+ STROBE_WINDOW + 9 * CPU_WINDOW + 5_000;

	logic       CLK_50M;
	logic       reset_wire;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	wb_addr_t   wb_adr;
	wb_data_t   wb_dat_w;
	wb_data_t   wb_dat_r;
	logic       wb_ack;
	logic       biu_done;
	ps2_lines_t ps2_in;
	logic       fm_clk;
	logic       reset_sys;
	logic       reset_cpu;
	logic       tandy_mode;
	logic       turbo;
	logic       cpu_ce;
	logic       periph_ce;
	logic       audio_ce;
	logic       fm_ce;
	ps2_lines_t ps2_sync;

	pcxt_glue_top dut0 (.*);

	initial begin
		CLK_50M = 1'b0;
		forever #CLK_HALF CLK_50M = ~CLK_50M;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$fatal(1);
	end

	// Stop at the first bound assertion failure
	initial begin
		wait (dut0.props0.assert_fails != 0);
		$display("a bound assertion on the DUT failed");
		$display("sim failed");
		$fatal(1);
	end

	////////////////////
	// Checks

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
		if (exp !== act)
			fail_now($sformatf("error %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act, input int tol);
		int diff;
		diff = act - exp;
		if (diff < 0)
			diff = -diff;
		if (diff > tol)
			fail_now($sformatf("error %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_lines(input string name, input ps2_lines_t exp, input ps2_lines_t act);
		if (exp !== act)
			fail_now($sformatf("error %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
			fail_now($sformatf("error %s expected %b actual %b", name, exp, act));
	endtask

	////////////////////
	// Expected rates

	// Strobes over n cycles, floor rule
	function automatic int floor_count(input int unsigned rate, input int n);
		return int'((longint'(n) * longint'(rate)) / longint'(SYS_CLK_HZ));
	endfunction

	// Code 3 counts as the slow rate
	function automatic int unsigned cpu_rate(input int code);
		if (code == 1)
			return CPU_RATE_MID_HZ;
		else if (code == 2)
			return CPU_RATE_FAST_HZ;
		return CPU_RATE_SLOW_HZ;
	endfunction

	////////////////////
	// Bus and helper tasks

	// Entered just after a falling edge, leaves one cycle after the ack
	task automatic wb_transfer(input logic we, input wb_addr_t adr, input wb_data_t dat,
		output wb_data_t rdat);
		int n;
		n        = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		@(negedge CLK_50M);
		while (!wb_ack && n < 8) begin
			@(negedge CLK_50M);
			n++;
		end
		if (!wb_ack)
			fail_now("Wishbone slave never acknowledged the transfer");
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge CLK_50M);
		if (wb_ack)
			fail_now("Wishbone acknowledge stayed high for a second cycle");
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		wb_data_t unused;
		wb_transfer(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		wb_transfer(1'b0, adr, '0, dat);
	endtask

	// Strobe counts over a window of falling edges
	task automatic count_window(input int n, output int audio, output int periph, output int cpu);
		audio  = 0;
		periph = 0;
		cpu    = 0;
		repeat (n) begin
			@(negedge CLK_50M);
			audio  += audio_ce;
			periph += periph_ce;
			cpu    += cpu_ce;
		end
	endtask

	task automatic wait_release();
		int n;
		n = 0;
		while (reset_cpu && n < RESET_HOLD_CYCLES + CPU_RESET_DELAY + 100) begin
			@(negedge CLK_50M);
			n++;
		end
		if (reset_cpu)
			fail_now("CPU reset was never released");
	endtask

	task automatic pulse_biu_done();
		biu_done = 1'b1;
		@(negedge CLK_50M);
		biu_done = 1'b0;
	endtask

	////////////////////
	// Tests

	task automatic test_reset_timing();
		int n;
		n = 0;
		while (reset_sys && n < RESET_HOLD_CYCLES + 100) begin
			@(negedge CLK_50M);
			n++;
		end
		check_count("reset_sys release edges", RESET_HOLD_CYCLES, n, 0);
		n = 0;
		while (reset_cpu && n < CPU_RESET_DELAY + 100) begin
			@(negedge CLK_50M);
			n++;
		end
		check_count("reset_cpu delay edges", CPU_RESET_DELAY, n, 0);
	endtask

	task automatic test_wb_transfers();
		wb_data_t wdat;
		wb_data_t rdat;
		// Bit 0 kept clear so the system stays out of reset
		for (int i = 0; i < 8; i++) begin
			wdat = $urandom & 32'hFFFF_FFFE;
			wb_write(ADDR_STATUS, wdat);
			wb_read(ADDR_STATUS, rdat);
			check_word("config readback", wdat, rdat);
		end
		wb_write(ADDR_STATE, $urandom);
		wb_read(ADDR_STATUS, rdat);
		check_word("config after state write", wdat, rdat);
		// Released, slow model latched at power-up, no turbo yet
		wb_read(ADDR_STATE, rdat);
		check_word("state word", 32'h0, rdat);
		wb_write(wb_addr_t'(2), $urandom);
		wb_read(wb_addr_t'(2), rdat);
		check_word("spare address", '0, rdat);
		wb_write(ADDR_STATUS, '0);
	endtask

	task automatic test_soft_reset();
		wb_data_t rdat;
		// Soft reset with the Tandy model
		wb_write(ADDR_STATUS, 32'h9);
		check_bit("reset_sys on soft reset", 1'b1, reset_sys);
		check_bit("reset_cpu on soft reset", 1'b1, reset_cpu);
		repeat (2) @(negedge CLK_50M);
		check_bit("tandy_mode in reset", 1'b1, tandy_mode);
		// Both resets and the model bit
		wb_read(ADDR_STATE, rdat);
		check_word("state word in soft reset", 32'h7, rdat);
		wb_write(ADDR_STATUS, 32'h1);
		repeat (2) @(negedge CLK_50M);
		check_bit("tandy_mode cleared in reset", 1'b0, tandy_mode);
		wb_write(ADDR_STATUS, 32'h9);
		repeat (2) @(negedge CLK_50M);
		// Release with the model still set
		wb_write(ADDR_STATUS, 32'h8);
		wait_release();
		check_bit("tandy_mode after release", 1'b1, tandy_mode);
		wb_write(ADDR_STATUS, 32'h0);
		repeat (4) @(negedge CLK_50M);
		check_bit("tandy_mode held", 1'b1, tandy_mode);
	endtask

	task automatic test_fixed_strobes();
		int audio;
		int periph;
		int cpu;
		count_window(STROBE_WINDOW, audio, periph, cpu);
		check_count("audio_ce count", floor_count(AUDIO_RATE_HZ, STROBE_WINDOW), audio, 1);
		check_count("periph_ce count", floor_count(PERIPH_RATE_HZ, STROBE_WINDOW), periph, 1);
	endtask

	task automatic test_cpu_speed();
		int       codes [4];
		int       prev;
		int       audio;
		int       periph;
		int       cpu;
		wb_data_t exp_state;
		wb_data_t rdat;
		codes = '{2, 1, 3, 0};
		prev  = 0;
		foreach (codes[i]) begin
			wb_write(ADDR_STATUS, wb_data_t'(codes[i]) << 17);
			count_window(CPU_WINDOW, audio, periph, cpu);
			check_count($sformatf("cpu_ce code %0d before biu_done", codes[i]),
				floor_count(cpu_rate(prev), CPU_WINDOW), cpu, 1);
			check_bit("turbo before biu_done", prev == 1 || prev == 2, turbo);
			pulse_biu_done();
			count_window(CPU_WINDOW, audio, periph, cpu);
			check_count($sformatf("cpu_ce code %0d after biu_done", codes[i]),
				floor_count(cpu_rate(codes[i]), CPU_WINDOW), cpu, 1);
			check_bit("turbo after biu_done", codes[i] == 1 || codes[i] == 2, turbo);
			// Model bit still set from the soft reset test
			exp_state = (codes[i] == 1 || codes[i] == 2) ? 32'hC : 32'h4;
			wb_read(ADDR_STATE, rdat);
			check_word("state word turbo", exp_state, rdat);
			prev = codes[i];
		end
	endtask

	task automatic test_synchronizers();
		ps2_lines_t hist [40];
		logic [1:0] r;
		int         hi;
		int         lo;
		// Keyboard lines lag by two edges
		for (int i = 0; i < 40; i++) begin
			if (i >= 2)
				check_lines("ps2_sync lag", hist[i-2], ps2_sync);
			r       = $urandom % 4;
			hist[i] = r;
			ps2_in  = hist[i];
			@(negedge CLK_50M);
		end
		// One fm_ce per rising edge, three cycles late
		for (int p = 0; p < 8; p++) begin
			hi     = 3 + $urandom % 4;
			lo     = 3 + $urandom % 3;
			fm_clk = 1'b1;
			for (int k = 1; k <= hi; k++) begin
				@(negedge CLK_50M);
				check_bit($sformatf("fm_ce high phase cycle %0d", k), k == 3, fm_ce);
			end
			fm_clk = 1'b0;
			repeat (lo) begin
				@(negedge CLK_50M);
				check_bit("fm_ce low phase", 1'b0, fm_ce);
			end
		end
	endtask

	////////////////////
	// Main sequence

	initial begin
		void'($urandom(68));
		reset_wire = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		biu_done   = 1'b0;
		ps2_in     = '0;
		fm_clk     = 1'b0;
		repeat (2) @(negedge CLK_50M);
		reset_wire = 1'b0;
		test_reset_timing();
		test_wb_transfers();
		test_soft_reset();
		test_fixed_strobes();
		test_cpu_speed();
		test_synchronizers();
		if (dut0.props0.assert_fails != 0) begin
			$display("bound assertions reported failures");
			$display("sim failed");
			$fatal(1);
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

//--- src.f
src/pcxt_pkg.sv
src/input_sync.sv
src/rate_strobe.sv
src/cfg_regs.sv
src/reset_sequencer.sv
src/clock_enables.sv
src/pcxt_glue_top.sv
bench/pcxt_glue_props.sv
bench/pcxt_glue_tb.sv

//--- Bender.yml
package:
  name: pcxt_glue

sources:
  # Synthesizable glue, package first
  - files:
      - src/pcxt_pkg.sv
      - src/input_sync.sv
      - src/rate_strobe.sv
      - src/cfg_regs.sv
      - src/reset_sequencer.sv
      - src/clock_enables.sv
      - src/pcxt_glue_top.sv

  # Bound assertions and testbench
  - target: simulation
    files:
      - bench/pcxt_glue_props.sv
      - bench/pcxt_glue_tb.sv
